// ==== rtl/rv_core.sv ====
`timescale 1ns/1ps

module rv_core #(
  parameter int IMEM_WORDS = 64,
  parameter int DMEM_WORDS = 64
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          prog_we,
  input  logic [$clog2(IMEM_WORDS)-1:0] prog_addr,
  input  rv_pkg::word_t                 prog_data,
  output logic                          is_halted,
  output rv_pkg::word_t                 reg_view [32]
);
  import rv_pkg::*;

  // decode side
  reg_idx_t rs1_idx, rs2_idx, id_rd;
  word_t    rs1_data, rs2_data, id_imm;
  alu_op_t  id_alu_op;
  wb_sel_t  id_wb_sel;
  logic     id_use_imm, id_mem_read, id_mem_write, id_reg_write, id_halt, id_bubble;
  // hazard feedback and ex/mem
  reg_idx_t ex_rd, mem_rd;
  logic     ex_reg_write, ex_mem_read, mem_reg_write, mem_mem_read, mem_mem_write;
  logic     mem_halt;
  word_t    mem_result, mem_store_data;
  wb_sel_t  mem_wb_sel;
  // writeback
  reg_idx_t wb_idx;
  word_t    wb_data;
  logic     wb_en;

  rv_fetch_decode #(.IMEM_WORDS(IMEM_WORDS)) fetch_decode_inst (.*);

  rv_reg_file reg_file_inst (.*);

  rv_execute execute_inst (.*);

  rv_mem_writeback #(.DMEM_WORDS(DMEM_WORDS)) mem_writeback_inst (.*);

endmodule

// ==== rtl/rv_execute.sv ====
`timescale 1ns/1ps

module rv_execute (
  input  logic             clk,
  input  logic             reset,
  input  rv_pkg::reg_idx_t id_rd,
  input  rv_pkg::word_t    id_imm,
  input  rv_pkg::alu_op_t  id_alu_op,
  input  logic             id_use_imm,
  input  logic             id_mem_read,
  input  logic             id_mem_write,
  input  logic             id_reg_write,
  input  rv_pkg::wb_sel_t  id_wb_sel,
  input  logic             id_halt,
  input  logic             id_bubble,
  input  rv_pkg::word_t    rs1_data,
  input  rv_pkg::word_t    rs2_data,
  input  rv_pkg::reg_idx_t rs1_idx,
  input  rv_pkg::reg_idx_t rs2_idx,
  input  rv_pkg::reg_idx_t wb_idx,
  input  rv_pkg::word_t    wb_data,
  input  logic             wb_en,
  output rv_pkg::reg_idx_t ex_rd,
  output logic             ex_reg_write,
  output logic             ex_mem_read,
  output rv_pkg::reg_idx_t mem_rd,
  output logic             mem_reg_write,
  output rv_pkg::word_t    mem_result,
  output rv_pkg::word_t    mem_store_data,
  output logic             mem_mem_read,
  output logic             mem_mem_write,
  output rv_pkg::wb_sel_t  mem_wb_sel,
  output logic             mem_halt
);
  import rv_pkg::*;

  // id/ex payload
  word_t    ex_rs1_data, ex_rs2_data, ex_imm;
  reg_idx_t ex_rs1_idx, ex_rs2_idx;
  // id/ex control
  alu_op_t  ex_alu_op;
  logic     ex_use_imm, ex_mem_write, ex_halt;
  wb_sel_t  ex_wb_sel;
  // ex stage datapath
  word_t    opnd_a, fwd_b, opnd_b, alu_result;

  always_ff @(posedge clk) begin
    if (reset || id_bubble) begin  // bubble leaves every enable low
      ex_rd        <= '0;
      ex_alu_op    <= alu_add;
      ex_use_imm   <= 1'b0;
      ex_mem_read  <= 1'b0;
      ex_mem_write <= 1'b0;
      ex_reg_write <= 1'b0;
      ex_wb_sel    <= wb_alu;
      ex_halt      <= 1'b0;
    end else begin
      ex_rd        <= id_rd;
      ex_alu_op    <= id_alu_op;
      ex_use_imm   <= id_use_imm;
      ex_mem_read  <= id_mem_read;
      ex_mem_write <= id_mem_write;
      ex_reg_write <= id_reg_write;
      ex_wb_sel    <= id_wb_sel;
      ex_halt      <= id_halt;
    end
  end

  always_ff @(posedge clk) begin
    ex_rs1_data <= rs1_data;
    ex_rs2_data <= rs2_data;
    ex_imm      <= id_imm;
    ex_rs1_idx  <= rs1_idx;
    ex_rs2_idx  <= rs2_idx;
  end

  // youngest producer wins, x0 never forwards
  assign opnd_a = (mem_reg_write && mem_rd != '0 && mem_rd == ex_rs1_idx) ? mem_result :
                  (wb_en && wb_idx != '0 && wb_idx == ex_rs1_idx) ? wb_data : ex_rs1_data;
  assign fwd_b  = (mem_reg_write && mem_rd != '0 && mem_rd == ex_rs2_idx) ? mem_result :
                  (wb_en && wb_idx != '0 && wb_idx == ex_rs2_idx) ? wb_data : ex_rs2_data;
  assign opnd_b = ex_use_imm ? ex_imm : fwd_b;  // fwd_b is also the store data

  always_comb begin
    case (ex_alu_op)
      alu_sub: alu_result = opnd_a - opnd_b;
      alu_and: alu_result = opnd_a & opnd_b;
      alu_or:  alu_result = opnd_a | opnd_b;
      alu_xor: alu_result = opnd_a ^ opnd_b;
      alu_slt: alu_result = {{(xlen-1){1'b0}}, $signed(opnd_a) < $signed(opnd_b)};
      default: alu_result = opnd_a + opnd_b;  // add, also address calc
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_rd        <= '0;
      mem_reg_write <= 1'b0;
      mem_mem_read  <= 1'b0;
      mem_mem_write <= 1'b0;
      mem_wb_sel    <= wb_alu;
      mem_halt      <= 1'b0;
    end else begin
      mem_rd        <= ex_rd;
      mem_reg_write <= ex_reg_write;
      mem_mem_read  <= ex_mem_read;
      mem_mem_write <= ex_mem_write;
      mem_wb_sel    <= ex_wb_sel;
      mem_halt      <= ex_halt;
    end
  end

  always_ff @(posedge clk) begin
    mem_result     <= alu_result;
    mem_store_data <= fwd_b;
  end

  a_no_load_store: assert property (@(posedge clk) disable iff (reset)
    !(mem_mem_read && mem_mem_write))
    else $error("ex/mem holds a load and a store");

endmodule

// ==== rtl/rv_fetch_decode.sv ====
`timescale 1ns/1ps

module rv_fetch_decode #(
  parameter int IMEM_WORDS = 64
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          prog_we,
  input  logic [$clog2(IMEM_WORDS)-1:0] prog_addr,
  input  rv_pkg::word_t                 prog_data,
  input  rv_pkg::word_t                 rs1_data,
  input  rv_pkg::reg_idx_t              ex_rd,
  input  logic                          ex_reg_write,
  input  logic                          ex_mem_read,
  input  rv_pkg::reg_idx_t              mem_rd,
  input  logic                          mem_reg_write,
  output rv_pkg::reg_idx_t              rs1_idx,
  output rv_pkg::reg_idx_t              rs2_idx,
  output rv_pkg::reg_idx_t              id_rd,
  output rv_pkg::word_t                 id_imm,
  output rv_pkg::alu_op_t               id_alu_op,
  output logic                          id_use_imm,
  output logic                          id_mem_read,
  output logic                          id_mem_write,
  output logic                          id_reg_write,
  output rv_pkg::wb_sel_t               id_wb_sel,
  output logic                          id_halt,
  output logic                          id_bubble
);
  import rv_pkg::*;

  localparam int imem_aw = $clog2(IMEM_WORDS);

  word_t             imem [IMEM_WORDS];  // program store, loaded under reset
  word_t             pc;
  word_t             if_id_inst;
  logic              fetch_stop;         // set once a halting ecall is decoded
  logic [imem_aw-1:0] pc_idx;
  logic [6:0]        opcode;
  logic [2:0]        funct3;
  logic              uses_rs1, uses_rs2, is_ecall;
  logic              load_use, ecall_wait, stall;

  function automatic alu_op_t decode_alu(logic [2:0] f3, logic sub);
    case (f3)
      f3_add_sub: return sub ? alu_sub : alu_add;
      f3_slt:     return alu_slt;
      f3_xor:     return alu_xor;
      f3_or:      return alu_or;
      f3_and:     return alu_and;
      default:    return alu_add;
    endcase
  endfunction

  assign pc_idx = pc[imem_aw+1:2];  // word index
  assign opcode = if_id_inst[6:0];
  assign funct3 = if_id_inst[14:12];

  always_ff @(posedge clk) begin
    if (prog_we) imem[prog_addr] <= prog_data;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc         <= '0;
      if_id_inst <= nop_inst;
      fetch_stop <= 1'b0;
    end else if (id_halt || fetch_stop) begin
      if_id_inst <= nop_inst;  // nothing past the halt enters decode
      fetch_stop <= 1'b1;
    end else if (!stall) begin
      pc         <= pc + 32'd4;
      if_id_inst <= imem[pc_idx];
    end
  end

  always_comb begin
    id_alu_op    = alu_add;
    id_use_imm   = 1'b0;
    id_mem_read  = 1'b0;
    id_mem_write = 1'b0;
    id_reg_write = 1'b0;
    id_wb_sel    = wb_alu;
    uses_rs1     = 1'b0;
    uses_rs2     = 1'b0;
    is_ecall     = 1'b0;
    case (opcode)
      op_reg: begin
        id_alu_op    = decode_alu(funct3, if_id_inst[31:25] == f7_sub);
        id_reg_write = 1'b1;
        uses_rs1     = 1'b1;
        uses_rs2     = 1'b1;
      end
      op_imm: begin
        id_alu_op    = decode_alu(funct3, 1'b0);  // no subtract form
        id_use_imm   = 1'b1;
        id_reg_write = 1'b1;
        uses_rs1     = 1'b1;
      end
      op_load: begin
        id_use_imm   = 1'b1;
        id_mem_read  = 1'b1;
        id_reg_write = 1'b1;
        id_wb_sel    = wb_load;
        uses_rs1     = 1'b1;
      end
      op_store: begin
        id_use_imm   = 1'b1;
        id_mem_write = 1'b1;
        uses_rs1     = 1'b1;
        uses_rs2     = 1'b1;  // store data
      end
      op_system: begin
        is_ecall = 1'b1;
        uses_rs1 = 1'b1;      // reads x17
      end
      default: ;  // decodes as a no-op
    endcase
  end

  // sign-extended s-immediate for stores, i-immediate otherwise
  assign id_imm = (opcode == op_store) ?
                  {{(xlen-12){if_id_inst[31]}}, if_id_inst[31:25], if_id_inst[11:7]} :
                  {{(xlen-12){if_id_inst[31]}}, if_id_inst[31:20]};

  assign rs1_idx = is_ecall ? halt_reg : if_id_inst[19:15];
  assign rs2_idx = if_id_inst[24:20];
  assign id_rd   = if_id_inst[11:7];

  assign load_use = ex_mem_read && (ex_rd != '0) &&
                    ((uses_rs1 && ex_rd == rs1_idx) || (uses_rs2 && ex_rd == rs2_idx));
  // x17 is read straight from the register file, so wait for older writers
  assign ecall_wait = is_ecall && ((ex_reg_write && ex_rd == halt_reg) ||
                                   (mem_reg_write && mem_rd == halt_reg));
  assign stall      = load_use || ecall_wait;
  assign id_bubble  = stall;
  assign id_halt    = is_ecall && !stall && (rs1_data == halt_code);

  a_prog_only_in_reset: assert property (@(posedge clk) prog_we |-> reset)
    else $error("program write outside reset");

endmodule

// ==== rtl/rv_mem_writeback.sv ====
`timescale 1ns/1ps

module rv_mem_writeback #(
  parameter int DMEM_WORDS = 64
) (
  input  logic             clk,
  input  logic             reset,
  input  rv_pkg::reg_idx_t mem_rd,
  input  logic             mem_reg_write,
  input  rv_pkg::word_t    mem_result,
  input  rv_pkg::word_t    mem_store_data,
  input  logic             mem_mem_read,
  input  logic             mem_mem_write,
  input  rv_pkg::wb_sel_t  mem_wb_sel,
  input  logic             mem_halt,
  output rv_pkg::reg_idx_t wb_idx,
  output rv_pkg::word_t    wb_data,
  output logic             wb_en,
  output logic             is_halted
);
  import rv_pkg::*;

  localparam int dmem_aw = $clog2(DMEM_WORDS);

  word_t              dmem [DMEM_WORDS];
  logic [dmem_aw-1:0] dmem_idx;
  word_t              wb_alu_result, wb_load_data;
  wb_sel_t            wb_sel;

  assign dmem_idx = mem_result[dmem_aw+1:2];  // byte address to word index

  always_ff @(posedge clk) begin
    if (mem_mem_write) dmem[dmem_idx] <= mem_store_data;
    wb_load_data  <= dmem[dmem_idx];  // load data lands in mem/wb
    wb_alu_result <= mem_result;
    wb_idx        <= mem_rd;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_en     <= 1'b0;
      wb_sel    <= wb_alu;
      is_halted <= 1'b0;
    end else begin
      wb_en  <= mem_reg_write;
      wb_sel <= mem_wb_sel;
      if (mem_halt) is_halted <= 1'b1;  // sticky until reset
    end
  end

  assign wb_data = (wb_sel == wb_load) ? wb_load_data : wb_alu_result;

  a_word_aligned: assert property (@(posedge clk) disable iff (reset)
    (mem_mem_read || mem_mem_write) |-> (mem_result[1:0] == 2'b00))
    else $error("unaligned data memory access");

endmodule

// ==== rtl/rv_pkg.sv ====
package rv_pkg;

  parameter int xlen = 32;  // data and address width

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0]      reg_idx_t;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt
  } alu_op_t;

  typedef enum logic {
    wb_alu,   // writeback takes the ALU result
    wb_load   // writeback takes the load data
  } wb_sel_t;

  // major opcodes of the kept subset
  parameter logic [6:0] op_reg    = 7'b0110011;
  parameter logic [6:0] op_imm    = 7'b0010011;
  parameter logic [6:0] op_load   = 7'b0000011;
  parameter logic [6:0] op_store  = 7'b0100011;
  parameter logic [6:0] op_system = 7'b1110011;

  // funct3 values
  parameter logic [2:0] f3_add_sub = 3'b000;  // add, sub, addi
  parameter logic [2:0] f3_slt     = 3'b010;
  parameter logic [2:0] f3_xor     = 3'b100;
  parameter logic [2:0] f3_or      = 3'b110;
  parameter logic [2:0] f3_and     = 3'b111;
  parameter logic [2:0] f3_word    = 3'b010;  // lw and sw

  // funct7 values
  parameter logic [6:0] f7_base = 7'b0000000;
  parameter logic [6:0] f7_sub  = 7'b0100000;

  // ecall halts when x17 holds 10
  parameter word_t    halt_code = 32'd10;
  parameter reg_idx_t halt_reg  = 5'd17;

  parameter word_t nop_inst = 32'h0000_0013;  // addi x0, x0, 0

endpackage

// ==== rtl/rv_reg_file.sv ====
`timescale 1ns/1ps

module rv_reg_file (
  input  logic             clk,
  input  logic             reset,
  input  rv_pkg::reg_idx_t rs1_idx,
  input  rv_pkg::reg_idx_t rs2_idx,
  input  rv_pkg::reg_idx_t wb_idx,
  input  rv_pkg::word_t    wb_data,
  input  logic             wb_en,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data,
  output rv_pkg::word_t    reg_view [32]
);
  import rv_pkg::*;

  word_t regs [32];
  logic  wr_live;  // a real write this cycle

  assign wr_live = wb_en && (wb_idx != '0);  // x0 is never written

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) regs[i] <= '0;
    end else if (wr_live) begin
      regs[wb_idx] <= wb_data;
    end
  end

  // write-through so decode sees the value being retired
  assign rs1_data = (rs1_idx == '0) ? '0 :
                    (wr_live && wb_idx == rs1_idx) ? wb_data : regs[rs1_idx];
  assign rs2_data = (rs2_idx == '0) ? '0 :
                    (wr_live && wb_idx == rs2_idx) ? wb_data : regs[rs2_idx];

  always_comb reg_view = regs;

endmodule

// ==== include/rv_tb_model.svh ====
`ifndef RV_TB_MODEL_SVH
`define RV_TB_MODEL_SVH

logic [31:0] lfsr_state = 32'd85267;

// x^32 + x^22 + x^2 + x + 1, one step per bit taken
function automatic logic [31:0] rand_bits(int n);
  logic [31:0] r;
  logic        fb;
  r = '0;
  for (int i = 0; i < n; i++) begin
    fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    r          = {r[30:0], fb};
  end
  return r;
endfunction

function automatic logic [31:0] enc_i(logic [11:0] imm, int rs1, logic [2:0] f3, int rd,
                                      logic [6:0] op);
  return {imm, 5'(rs1), f3, 5'(rd), op};
endfunction

// kind 0 add, 1 sub, 2 and, 3 or, 4 xor, 5 slt
function automatic logic [31:0] enc_r(int kind, int rd, int rs1, int rs2);
  logic [2:0] f3;
  case (kind)
    2:       f3 = 3'b111;
    3:       f3 = 3'b110;
    4:       f3 = 3'b100;
    5:       f3 = 3'b010;
    default: f3 = 3'b000;  // add and sub share funct3
  endcase
  return {(kind == 1) ? 7'b0100000 : 7'b0000000, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
endfunction

task automatic build_program();
  logic [15:0] written;  // data words already stored to
  int          kind, rd, rs1, rs2, addr, i;
  written = '0;
  i       = 0;
  while (i < body_len) begin
    kind = rand_bits(4);
    rd   = rand_bits(3);
    rs1  = rand_bits(3);
    rs2  = rand_bits(3);
    addr = rand_bits(4);
    if (i == mid_at) begin  // ecall with x17 in 3..6
      prog[i]   = enc_i(12'(3 + rand_bits(2)), 0, 3'b000, 17, 7'b0010011);
      prog[i+1] = 32'h0000_0073;
      i += 2;
    end else if (kind < 6) begin
      prog[i] = enc_r(kind, rd, rs1, rs2);
      i += 1;
    end else if (kind < 9) begin
      prog[i] = enc_i(12'(rand_bits(12)), rs1, 3'b000, rd, 7'b0010011);  // any sign
      i += 1;
    end else if (kind < 12 && written[addr] && i + 1 != mid_at && i + 1 < body_len) begin
      rd        = (rd == 0) ? 1 : rd;
      prog[i]   = enc_i(12'(addr * 4), 0, 3'b010, rd, 7'b0000011);
      prog[i+1] = enc_r(0, rs2, rd, rs1);  // user right behind the load
      i += 2;
    end else begin
      prog[i] = {7'(addr >> 3), 5'(rs2), 5'd0, 3'b010, 5'(addr << 2), 7'b0100011};
      written[addr] = 1'b1;
      i += 1;
    end
  end
  prog[body_len]   = enc_i(12'd10, 0, 3'b000, 17, 7'b0010011);  // x17 = 10
  prog[body_len+1] = 32'h0000_0073;                              // halting ecall
  for (int f = 0; f < fill_len; f++)
    prog[body_len+2+f] = enc_i(12'hfff - 12'(f), 0, 3'b000, f + 1, 7'b0010011);
endtask

// in-order interpreter, stops at the ecall that sees x17 == 10
task automatic run_model();
  logic [31:0] inst, a, b, res;
  logic [31:0] data_words [16];
  logic        wr, stop;
  int          pc;
  for (int r = 0; r < 32; r++) model_regs[r] = '0;
  pc   = 0;
  stop = 1'b0;
  while (!stop && pc < prog_len) begin
    inst = prog[pc];
    a    = model_regs[inst[19:15]];
    b    = model_regs[inst[24:20]];
    wr   = 1'b1;
    case (inst[6:0])
      7'b0110011: case (inst[14:12])
        3'b111:  res = a & b;
        3'b110:  res = a | b;
        3'b100:  res = a ^ b;
        3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        default: res = inst[30] ? a - b : a + b;
      endcase
      7'b0010011: res = a + {{20{inst[31]}}, inst[31:20]};  // addi
      7'b0000011: res = data_words[(a + {{20{inst[31]}}, inst[31:20]}) >> 2];
      7'b0100011: begin
        data_words[(a + {{20{inst[31]}}, inst[31:25], inst[11:7]}) >> 2] = b;
        wr = 1'b0;
      end
      default: begin  // ecall
        stop = (model_regs[17] == 32'd10);
        wr   = 1'b0;
      end
    endcase
    if (wr && inst[11:7] != 5'd0) model_regs[inst[11:7]] = res;
    pc++;
  end
endtask

`endif

// ==== verif/rv_core_tb.sv ====
`timescale 1ns/1ps

module rv_core_tb;

  localparam int imem_words  = 64;
  localparam int dmem_words  = 64;
  localparam int imem_aw     = $clog2(imem_words);
  localparam int body_len    = 40;            // random part of the program
  localparam int mid_at      = body_len / 2;  // non-halting ecall pair
  localparam int fill_len    = 3;             // behind the halting ecall
  localparam int prog_len    = body_len + 2 + fill_len;
  localparam int cycle_limit = 4 + 5 + 3 * prog_len + 20;
  localparam int halt_min    = body_len + 1 + 4;  // halting ecall into MEM/WB, no stalls

  logic               clk;
  logic               reset;
  logic               prog_we;
  logic [imem_aw-1:0] prog_addr;
  logic [31:0]        prog_data;
  logic               is_halted;
  logic [31:0]        reg_view [32];

  logic [31:0] prog [prog_len];
  logic [31:0] model_regs [32];
  int          cycle_count;  // edges since reset release
  int          check_count;
  int          err_count;

  `include "rv_tb_model.svh"

  rv_core #(.IMEM_WORDS(imem_words), .DMEM_WORDS(dmem_words)) rv_core_inst (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    if (reset) cycle_count <= 0;
    else cycle_count <= cycle_count + 1;
  end

  a_halt_not_early: assert property (@(posedge clk) disable iff (reset)
    is_halted |-> cycle_count >= halt_min)
    else begin
      err_count++;
      $display("ERROR @%0t: is_halted high after %0d cycles, earliest legal %0d",
               $time, cycle_count, halt_min);
    end

  a_halt_sticky: assert property (@(posedge clk) disable iff (reset) is_halted |=> is_halted)
    else begin
      err_count++;
      $display("ERROR @%0t: is_halted dropped without reset", $time);
    end

  a_x0_zero: assert property (@(posedge clk) disable iff (reset) reg_view[0] == '0)
    else begin
      err_count++;
      $display("ERROR @%0t: x0 reads %h", $time, reg_view[0]);
    end

  task automatic compare_regs(string when);
    for (int r = 0; r < 32; r++) begin
      check_count++;
      assert (reg_view[r] === model_regs[r])
        else begin
          err_count++;
          $display("ERROR @%0t: %s x%0d = %h, expected %h",
                   $time, when, r, reg_view[r], model_regs[r]);
        end
    end
  endtask

  initial begin
    reset       = 1'b1;
    prog_we     = 1'b0;
    prog_addr   = '0;
    prog_data   = '0;
    check_count = 0;
    err_count   = 0;
    build_program();
    run_model();
    for (int i = 0; i < prog_len; i++) begin  // program load while reset holds
      @(posedge clk);
      prog_we   <= 1'b1;
      prog_addr <= imem_aw'(i);
      prog_data <= prog[i];
    end
    @(posedge clk);
    prog_we <= 1'b0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    while (!is_halted && cycle_count < cycle_limit) @(negedge clk);
    if (!is_halted) begin
      err_count++;
      $display("core never halted within %0d cycles", cycle_limit);
    end else begin
      compare_regs("at halt");
      repeat (10) @(negedge clk);
      compare_regs("after halt");  // filler past the ecall must not retire
    end
    $display("checks: %0d  errors: %0d", check_count, err_count);
    if (err_count == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+include
rtl/rv_pkg.sv
rtl/rv_reg_file.sv
rtl/rv_fetch_decode.sv
rtl/rv_execute.sv
rtl/rv_mem_writeback.sv
rtl/rv_core.sv
verif/rv_core_tb.sv
